// ==== hw/mac_pe.sv ====
// Multiply-accumulate processing element
`timescale 1ns/1ps
`default_nettype none

module mac_pe import sa_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_clear,
    input  logic              i_shift,
    input  logic [DATA_W-1:0] i_west,
    input  logic [DATA_W-1:0] i_south,
    input  logic [DATA_W-1:0] i_east_acc,  // neighbor result during drain
    output logic [DATA_W-1:0] o_east,
    output logic [DATA_W-1:0] o_north,
    output logic [DATA_W-1:0] o_acc
);

    logic [DATA_W-1:0] product;

    assign product = i_west * i_south;  // wraps to DATA_W

    always_ff @(posedge clk) begin
        if (i_rst || i_clear) begin
            o_east  <= '0;  // empty pipeline so padding stays zero
            o_north <= '0;
            o_acc   <= '0;
        end else begin
            o_east  <= i_west;
            o_north <= i_south;
            if (i_shift)
                o_acc <= i_east_acc;
            else
                o_acc <= o_acc + product;
        end
    end

endmodule

`default_nettype wire

// ==== hw/operand_store.sv ====
// Operand store and skewed feed
`timescale 1ns/1ps
`default_nettype none

module operand_store import sa_pkg::*; #(
    parameter int ROWS   = ROWS_DEF,
    parameter int COLS   = COLS_DEF,
    parameter int DEPTH  = DEPTH_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic                                          clk,
    input  logic                                          i_rst,
    input  logic                                          i_wr_en,
    input  operand_sel_e                                  i_wr_sel,
    input  logic [idx_w(ROWS > DEPTH ? ROWS : DEPTH)-1:0] i_wr_row,
    input  logic [idx_w(COLS > DEPTH ? COLS : DEPTH)-1:0] i_wr_col,
    input  logic [DATA_W-1:0]                             i_wr_data,
    input  logic                                          i_busy,
    sa_ctrl_if.feed                                       ctl,
    output logic [ROWS-1:0][DATA_W-1:0]                   o_west_vec,
    output logic [COLS-1:0][DATA_W-1:0]                   o_south_vec,
    output logic [ROWS-1:0][DATA_W-1:0]                   o_m_col
);

    logic [DATA_W-1:0] a_mem [ROWS][DEPTH];  // a[i][k]
    logic [DATA_W-1:0] b_mem [DEPTH][COLS];  // b[k][j]
    logic [DATA_W-1:0] m_mem [ROWS][COLS];
    logic              wr_in_bounds;

    always_comb begin
        case (i_wr_sel)
            OP_A:    wr_in_bounds = (i_wr_row < ROWS) && (i_wr_col < DEPTH);
            OP_B:    wr_in_bounds = (i_wr_row < DEPTH) && (i_wr_col < COLS);
            OP_M:    wr_in_bounds = (i_wr_row < ROWS) && (i_wr_col < COLS);
            default: wr_in_bounds = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_wr_en && !i_busy && wr_in_bounds) begin  // writes while busy are dropped
            case (i_wr_sel)
                OP_A:    a_mem[i_wr_row][i_wr_col] <= i_wr_data;
                OP_B:    b_mem[i_wr_row][i_wr_col] <= i_wr_data;
                OP_M:    m_mem[i_wr_row][i_wr_col] <= i_wr_data;
                default: ;
            endcase
        end
    end

    // row i gets a[i][t-i], column j gets b[t-j][j], zero outside the matrix
    always_ff @(posedge clk) begin
        if (i_rst || !ctl.feed_en) begin
            o_west_vec  <= '0;
            o_south_vec <= '0;
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                if (ctl.feed_step >= r && ctl.feed_step < r + DEPTH)
                    o_west_vec[r] <= a_mem[r][ctl.feed_step - r];
                else
                    o_west_vec[r] <= '0;
            end
            for (int c = 0; c < COLS; c++) begin
                if (ctl.feed_step >= c && ctl.feed_step < c + DEPTH)
                    o_south_vec[c] <= b_mem[ctl.feed_step - c][c];
                else
                    o_south_vec[c] <= '0;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < ROWS; r++)
            o_m_col[r] = m_mem[r][ctl.drain_col];  // m column matching the drained results
    end

    a_wr_bounds: assert property (@(posedge clk) disable iff (i_rst)
        (i_wr_en && !i_busy) |-> wr_in_bounds);

endmodule

`default_nettype wire

// ==== hw/pe_grid.sv ====
// Systolic PE grid
`timescale 1ns/1ps
`default_nettype none

module pe_grid import sa_pkg::*; #(
    parameter int ROWS   = ROWS_DEF,
    parameter int COLS   = COLS_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic                        clk,
    input  logic                        i_rst,
    sa_ctrl_if.grid                     ctl,
    input  logic [ROWS-1:0][DATA_W-1:0] i_west_vec,
    input  logic [COLS-1:0][DATA_W-1:0] i_south_vec,
    output logic [ROWS-1:0][DATA_W-1:0] o_west_acc
);

    logic [DATA_W-1:0] a_east  [ROWS][COLS];  // a operands moving east
    logic [DATA_W-1:0] b_north [ROWS][COLS];  // b operands moving north
    logic [DATA_W-1:0] acc     [ROWS][COLS];

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        for (genvar j = 0; j < COLS; j++) begin : g_col
            logic [DATA_W-1:0] west_in;
            logic [DATA_W-1:0] south_in;
            logic [DATA_W-1:0] east_acc_in;

            if (j == 0) begin : g_w_edge
                assign west_in = i_west_vec[i];
            end else begin : g_w_inner
                assign west_in = a_east[i][j-1];
            end

            if (i == 0) begin : g_s_edge
                assign south_in = i_south_vec[j];
            end else begin : g_s_inner
                assign south_in = b_north[i-1][j];
            end

            if (j == COLS - 1) begin : g_e_edge
                assign east_acc_in = '0;  // east edge shifts in zero
            end else begin : g_e_inner
                assign east_acc_in = acc[i][j+1];
            end

            mac_pe #(
                .DATA_W (DATA_W)
            ) u_pe (
                .clk        (clk),
                .i_rst      (i_rst),
                .i_clear    (ctl.clear),
                .i_shift    (ctl.drain_shift),
                .i_west     (west_in),
                .i_south    (south_in),
                .i_east_acc (east_acc_in),
                .o_east     (a_east[i][j]),
                .o_north    (b_north[i][j]),
                .o_acc      (acc[i][j])
            );
        end

        assign o_west_acc[i] = acc[i][0];
    end

    a_no_clear_in_drain: assert property (@(posedge clk) disable iff (i_rst)
        !(ctl.clear && ctl.drain_shift));

endmodule

`default_nettype wire

// ==== hw/phase_sequencer.sv ====
// Phase sequencer FSM
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer import sa_pkg::*; #(
    parameter int ROWS  = ROWS_DEF,
    parameter int COLS  = COLS_DEF,
    parameter int DEPTH = DEPTH_DEF
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_start,
    input  adder_mode_e i_mode,
    sa_ctrl_if.ctrl     ctl,
    output adder_mode_e o_mode,
    output logic        o_busy,
    output logic        o_done
);

    localparam int FEED_STEPS = feed_steps(DEPTH, ROWS, COLS);

    seq_state_e state;
    logic       start_ok;
    logic       drain_last;
    logic       done_pend;  // last result leaves the combiner this cycle

    assign start_ok        = (state == ST_IDLE) && i_start && !o_busy;
    assign ctl.clear       = (state == ST_CLEAR);
    assign ctl.feed_en     = (state == ST_FEED);
    assign ctl.drain_shift = (state == ST_DRAIN);
    assign drain_last      = ctl.drain_shift && (ctl.drain_col == COLS - 1);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state         <= ST_IDLE;
            ctl.feed_step <= '0;
            ctl.drain_col <= '0;
            o_mode        <= MODE_PASS;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        state  <= ST_CLEAR;
                        o_mode <= i_mode;  // held for the whole job
                    end
                end
                ST_CLEAR: begin
                    state         <= ST_FEED;
                    ctl.feed_step <= '0;
                end
                ST_FEED: begin
                    if (ctl.feed_step == FEED_STEPS - 1) begin
                        state         <= ST_FLUSH;
                        ctl.feed_step <= '0;  // step counter reused for the flush
                    end else begin
                        ctl.feed_step <= ctl.feed_step + 1'b1;
                    end
                end
                ST_FLUSH: begin
                    // two cycles so the far corner PE takes its last product
                    if (ctl.feed_step == 1) begin
                        state         <= ST_DRAIN;
                        ctl.feed_step <= '0;
                        ctl.drain_col <= '0;
                    end else begin
                        ctl.feed_step <= ctl.feed_step + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (drain_last) begin
                        state         <= ST_IDLE;
                        ctl.drain_col <= '0;
                    end else begin
                        ctl.drain_col <= ctl.drain_col + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_busy    <= 1'b0;
            done_pend <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            done_pend <= drain_last;
            o_done    <= done_pend;
            if (start_ok)
                o_busy <= 1'b1;
            else if (done_pend)
                o_busy <= 1'b0;  // falls together with o_done
        end
    end

    a_done_not_feeding: assert property (@(posedge clk) disable iff (i_rst)
        o_done |-> !ctl.feed_en);

endmodule

`default_nettype wire

// ==== hw/row_combiner.sv ====
// Row result combiner
`timescale 1ns/1ps
`default_nettype none

module row_combiner import sa_pkg::*; #(
    parameter int ROWS   = ROWS_DEF,
    parameter int COLS   = COLS_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic                        clk,
    input  logic                        i_rst,
    sa_ctrl_if.comb                     ctl,
    input  adder_mode_e                 i_mode,
    input  logic [ROWS-1:0][DATA_W-1:0] i_acc_col,
    input  logic [ROWS-1:0][DATA_W-1:0] i_m_col,
    output logic                        o_res_valid,
    output logic [idx_w(COLS)-1:0]      o_res_col,
    output logic [ROWS-1:0][DATA_W-1:0] o_res_data
);

    logic [ROWS-1:0][DATA_W-1:0] comb_val;

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            case (i_mode)
                MODE_ADD: comb_val[r] = i_acc_col[r] + i_m_col[r];
                MODE_SUB: comb_val[r] = i_acc_col[r] - i_m_col[r];  // wraps below zero
                default:  comb_val[r] = i_acc_col[r];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            o_res_valid <= 1'b0;
        else
            o_res_valid <= ctl.drain_shift;
    end

    always_ff @(posedge clk) begin
        if (ctl.clear) begin
            o_res_data <= '0;  // drop the previous job's last column
            o_res_col  <= '0;
        end else if (ctl.drain_shift) begin
            o_res_data <= comb_val;
            o_res_col  <= ctl.drain_col;
        end
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (i_rst)
        ctl.drain_shift |-> (i_mode inside {MODE_PASS, MODE_ADD, MODE_SUB}));

endmodule

`default_nettype wire

// ==== hw/sa_ctrl_if.sv ====
// Phase control bundle
`timescale 1ns/1ps
`default_nettype none

interface sa_ctrl_if import sa_pkg::*; #(
    parameter int DEPTH = DEPTH_DEF,
    parameter int ROWS  = ROWS_DEF,
    parameter int COLS  = COLS_DEF
);

    logic                                              clear;       // zero accumulators
    logic                                              feed_en;     // skewed feed active
    logic [idx_w(feed_steps(DEPTH, ROWS, COLS))-1:0]   feed_step;
    logic                                              drain_shift; // move results west
    logic [idx_w(COLS)-1:0]                            drain_col;   // column at west edge

    modport ctrl (output clear, feed_en, feed_step, drain_shift, drain_col);
    modport feed (input feed_en, feed_step, drain_col);
    modport grid (input clear, drain_shift);
    modport comb (input clear, drain_shift, drain_col);

endinterface

`default_nettype wire

// ==== hw/sa_pkg.sv ====
// Systolic array shared definitions
`default_nettype none

package sa_pkg;

    localparam int ROWS_DEF   = 4;
    localparam int COLS_DEF   = 4;
    localparam int DEPTH_DEF  = 4;
    localparam int DATA_W_DEF = 16;

    // cycles to push every skewed operand through the grid
    function automatic int feed_steps(input int depth, input int rows, input int cols);
        return depth + rows + cols - 2;
    endfunction

    // bits to index n entries, at least one
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    localparam int FEED_STEPS_DEF = feed_steps(DEPTH_DEF, ROWS_DEF, COLS_DEF);

    typedef enum logic [1:0] {
        MODE_PASS = 2'd0,  // c = a*b
        MODE_ADD  = 2'd1,  // c = a*b + m
        MODE_SUB  = 2'd2   // c = a*b - m
    } adder_mode_e;

    typedef enum logic [1:0] {
        OP_A = 2'd0,
        OP_B = 2'd1,
        OP_M = 2'd2
    } operand_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_CLEAR = 3'd1,
        ST_FEED  = 3'd2,
        ST_FLUSH = 3'd3,
        ST_DRAIN = 3'd4
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/systolic_top.sv ====
// Systolic array top level
`timescale 1ns/1ps
`default_nettype none

module systolic_top import sa_pkg::*; #(
    parameter int ROWS   = ROWS_DEF,
    parameter int COLS   = COLS_DEF,
    parameter int DEPTH  = DEPTH_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic                                          clk,
    input  logic                                          i_rst,
    input  logic                                          i_wr_en,
    input  operand_sel_e                                  i_wr_sel,
    input  logic [idx_w(ROWS > DEPTH ? ROWS : DEPTH)-1:0] i_wr_row,
    input  logic [idx_w(COLS > DEPTH ? COLS : DEPTH)-1:0] i_wr_col,
    input  logic [DATA_W-1:0]                             i_wr_data,
    input  logic                                          i_start,
    input  adder_mode_e                                   i_mode,
    output logic                                          o_busy,
    output logic                                          o_res_valid,
    output logic [idx_w(COLS)-1:0]                        o_res_col,
    output logic [ROWS-1:0][DATA_W-1:0]                   o_res_data,
    output logic                                          o_done
);

    adder_mode_e                 job_mode;   // mode latched at start
    logic [ROWS-1:0][DATA_W-1:0] west_vec;
    logic [COLS-1:0][DATA_W-1:0] south_vec;
    logic [ROWS-1:0][DATA_W-1:0] west_acc;   // drained column
    logic [ROWS-1:0][DATA_W-1:0] m_col;

    sa_ctrl_if #(.DEPTH(DEPTH), .ROWS(ROWS), .COLS(COLS)) ctl_if ();

    phase_sequencer #(.ROWS(ROWS), .COLS(COLS), .DEPTH(DEPTH)) u_seq (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_start (i_start),
        .i_mode  (i_mode),
        .ctl     (ctl_if.ctrl),
        .o_mode  (job_mode),
        .o_busy  (o_busy),
        .o_done  (o_done)
    );

    operand_store #(.ROWS(ROWS), .COLS(COLS), .DEPTH(DEPTH), .DATA_W(DATA_W)) u_store (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wr_en     (i_wr_en),
        .i_wr_sel    (i_wr_sel),
        .i_wr_row    (i_wr_row),
        .i_wr_col    (i_wr_col),
        .i_wr_data   (i_wr_data),
        .i_busy      (o_busy),
        .ctl         (ctl_if.feed),
        .o_west_vec  (west_vec),
        .o_south_vec (south_vec),
        .o_m_col     (m_col)
    );

    pe_grid #(.ROWS(ROWS), .COLS(COLS), .DATA_W(DATA_W)) u_grid (
        .clk         (clk),
        .i_rst       (i_rst),
        .ctl         (ctl_if.grid),
        .i_west_vec  (west_vec),
        .i_south_vec (south_vec),
        .o_west_acc  (west_acc)
    );

    row_combiner #(.ROWS(ROWS), .COLS(COLS), .DATA_W(DATA_W)) u_comb (
        .clk         (clk),
        .i_rst       (i_rst),
        .ctl         (ctl_if.comb),
        .i_mode      (job_mode),
        .i_acc_col   (west_acc),
        .i_m_col     (m_col),
        .o_res_valid (o_res_valid),
        .o_res_col   (o_res_col),
        .o_res_data  (o_res_data)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
hw/sa_pkg.sv
hw/sa_ctrl_if.sv
hw/operand_store.sv
hw/mac_pe.sv
hw/pe_grid.sv
hw/row_combiner.sv
hw/phase_sequencer.sv
hw/systolic_top.sv
tests/tb_systolic.sv

// ==== tests/tb_model.svh ====
// Testbench reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit LCG, one step per call
function automatic logic [DATA_W-1:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];  // upper bits have the longer period
endfunction

// expected c[i][j] straight from the matrix definition, wrapped to DATA_W
function automatic logic [DATA_W-1:0] expected_entry(input int i, input int j,
                                                     input adder_mode_e mode);
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] prod;
    sum = '0;
    for (int k = 0; k < DEPTH; k++) begin
        prod = a_m[i][k] * b_m[k][j];  // low DATA_W bits only
        sum  = sum + prod;
    end
    case (mode)
        MODE_ADD: return sum + m_m[i][j];
        MODE_SUB: return sum - m_m[i][j];  // negative results wrap
        default:  return sum;
    endcase
endfunction

`endif

// ==== tests/tb_systolic.sv ====
// Systolic array testbench
`timescale 1ns/1ps
`default_nettype none

module tb_systolic import sa_pkg::*;;

    localparam int ROWS        = ROWS_DEF;
    localparam int COLS        = COLS_DEF;
    localparam int DEPTH       = DEPTH_DEF;
    localparam int DATA_W      = DATA_W_DEF;
    localparam int JOB_TIMEOUT = 200;  // cycles, far above the real latency

    logic                                          clk = 1'b0;
    logic                                          i_rst;
    logic                                          i_wr_en;
    operand_sel_e                                  i_wr_sel;
    logic [idx_w(ROWS > DEPTH ? ROWS : DEPTH)-1:0] i_wr_row;
    logic [idx_w(COLS > DEPTH ? COLS : DEPTH)-1:0] i_wr_col;
    logic [DATA_W-1:0]                             i_wr_data;
    logic                                          i_start;
    adder_mode_e                                   i_mode;
    logic                                          o_busy;
    logic                                          o_res_valid;
    logic [idx_w(COLS)-1:0]                        o_res_col;
    logic [ROWS-1:0][DATA_W-1:0]                   o_res_data;
    logic                                          o_done;

    logic [DATA_W-1:0] a_m [ROWS][DEPTH];  // model copies of the operands
    logic [DATA_W-1:0] b_m [DEPTH][COLS];
    logic [DATA_W-1:0] m_m [ROWS][COLS];
    logic [31:0]       lcg_state = 32'h8c14_370e;
    adder_mode_e       exp_mode;
    string             cur_test;
    logic              check_b;  // identity test: results must equal b
    int                next_col;
    int                valid_count;
    int                test_errors;
    int                total_errors;
    int                tests_run;
    int                tests_failed;

    systolic_top #(.ROWS(ROWS), .COLS(COLS), .DEPTH(DEPTH), .DATA_W(DATA_W)) uut (
        .clk (clk), .i_rst (i_rst), .i_wr_en (i_wr_en), .i_wr_sel (i_wr_sel),
        .i_wr_row (i_wr_row), .i_wr_col (i_wr_col), .i_wr_data (i_wr_data),
        .i_start (i_start), .i_mode (i_mode), .o_busy (o_busy),
        .o_res_valid (o_res_valid), .o_res_col (o_res_col),
        .o_res_data (o_res_data), .o_done (o_done)
    );

    always #4 clk = ~clk;

    // outputs change on the rising edge, so compare on the falling one
    always @(negedge clk) begin
        logic [DATA_W-1:0] exp_val;
        if (!i_rst && o_res_valid) begin
            if (next_col >= COLS) begin
                $display("unexpected result strobe after the last column in %s", cur_test);
                test_errors++;
            end else begin
                assert (o_res_col == next_col) else begin
                    $display("MISMATCH %s column expected %0d actual %0d",
                             cur_test, next_col, o_res_col);
                    test_errors++;
                end
                for (int r = 0; r < ROWS; r++) begin
                    exp_val = expected_entry(r, next_col, exp_mode);
                    assert (o_res_data[r] == exp_val) else begin
                        $display("MISMATCH %s c[%0d][%0d] expected %h actual %h",
                                 cur_test, r, next_col, exp_val, o_res_data[r]);
                        test_errors++;
                    end
                    if (check_b) begin
                        assert (o_res_data[r] == b_m[r][next_col]) else begin
                            $display("MISMATCH %s b[%0d][%0d] expected %h actual %h",
                                     cur_test, r, next_col, b_m[r][next_col], o_res_data[r]);
                            test_errors++;
                        end
                    end
                end
            end
            next_col++;
            valid_count++;
        end
    end

    task automatic abort_run(input string what);
        $display("%s in test %s", what, cur_test);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic write_word(input operand_sel_e sel, input int row, input int col,
                              input logic [DATA_W-1:0] data);
        @(negedge clk);
        i_wr_en   = 1'b1;
        i_wr_sel  = sel;
        i_wr_row  = $bits(i_wr_row)'(row);
        i_wr_col  = $bits(i_wr_col)'(col);
        i_wr_data = data;
    endtask

    task automatic fill_random();
        for (int i = 0; i < ROWS; i++)
            for (int k = 0; k < DEPTH; k++)
                a_m[i][k] = next_rand();
        for (int k = 0; k < DEPTH; k++)
            for (int j = 0; j < COLS; j++)
                b_m[k][j] = next_rand();
        for (int i = 0; i < ROWS; i++)
            for (int j = 0; j < COLS; j++)
                m_m[i][j] = next_rand();
    endtask

    task automatic load_operands();
        for (int i = 0; i < ROWS; i++)
            for (int k = 0; k < DEPTH; k++)
                write_word(OP_A, i, k, a_m[i][k]);  // column index is k
        for (int k = 0; k < DEPTH; k++)
            for (int j = 0; j < COLS; j++)
                write_word(OP_B, k, j, b_m[k][j]);  // row index is k
        for (int i = 0; i < ROWS; i++)
            for (int j = 0; j < COLS; j++)
                write_word(OP_M, i, j, m_m[i][j]);
        @(negedge clk);
        i_wr_en = 1'b0;
    endtask

    task automatic start_job(input adder_mode_e mode);
        @(negedge clk);
        exp_mode    = mode;
        next_col    = 0;
        valid_count = 0;
        i_start     = 1'b1;
        i_mode      = mode;
        @(negedge clk);
        i_start = 1'b0;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!o_busy && n < JOB_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!o_busy)
            abort_run("timed out waiting for busy");
    endtask

    // waits for done, then checks the strobe count and the busy level
    task automatic wait_done();
        int n;
        n = 0;
        while (!o_done && n < JOB_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!o_done) begin
            abort_run("timed out waiting for done");
        end else begin
            assert (valid_count == COLS) else begin
                $display("MISMATCH %s result strobes expected %0d actual %0d",
                         cur_test, COLS, valid_count);
                test_errors++;
            end
            assert (!o_busy) else begin
                $display("busy still high together with done in test %s", cur_test);
                test_errors++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
            $display("test %s passed", cur_test);
        else
            $display("test %s failed with %0d errors", cur_test, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
    endtask

    initial begin
        i_rst        = 1'b1;
        i_wr_en      = 1'b0;
        i_wr_sel     = OP_A;
        i_wr_row     = '0;
        i_wr_col     = '0;
        i_wr_data    = '0;
        i_start      = 1'b0;
        i_mode       = MODE_PASS;
        exp_mode     = MODE_PASS;
        check_b      = 1'b0;
        next_col     = 0;
        valid_count  = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;

        begin_test("identity");
        fill_random();
        for (int i = 0; i < ROWS; i++)
            for (int k = 0; k < DEPTH; k++)
                a_m[i][k] = (i == k) ? 1 : 0;
        load_operands();
        check_b = 1'b1;
        start_job(MODE_PASS);
        wait_done();
        check_b = 1'b0;
        end_test();

        begin_test("random_add");
        fill_random();
        load_operands();
        start_job(MODE_ADD);
        wait_done();
        end_test();

        begin_test("random_sub");
        fill_random();
        load_operands();
        start_job(MODE_SUB);
        wait_done();
        end_test();

        begin_test("busy_writes");
        fill_random();
        load_operands();
        start_job(MODE_ADD);
        wait_busy();
        for (int k = 0; k < DEPTH; k++)
            write_word(OP_A, ROWS - 1, k, 16'hdead);  // lands during the feed if not dropped
        write_word(OP_B, DEPTH - 1, COLS - 1, 16'hbeef);  // read late in the feed
        i_start = 1'b1;
        i_mode  = MODE_SUB;
        @(negedge clk);
        i_start = 1'b0;
        i_wr_en = 1'b0;
        wait_done();
        repeat (2 * JOB_TIMEOUT / 5) begin
            @(negedge clk);
            assert (!o_busy && !o_res_valid) else begin
                $display("extra job ran after done in test %s", cur_test);
                test_errors++;
            end
        end
        start_job(MODE_ADD);  // same operands again, the dropped writes must not show
        wait_done();
        end_test();

        begin_test("back_to_back");
        repeat (2) begin
            fill_random();
            load_operands();
            start_job(MODE_ADD);
            wait_done();
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0 && total_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    `include "tb_model.svh"

endmodule

`default_nettype wire
